// File: build.f
+incdir+include
raytracer_pkg.sv
hdl/ray_gen.sv
hdl/sphere_bank.sv
hdl/hit_shader.sv
hdl/raytracer_top.sv
verif/raytracer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the raytracer testbench with Verilator and runs it; the exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module raytracer_tb \
    -f build.f

./obj_dir/Vraytracer_tb

// File: include/raytracer_ref.svh
// Golden colour model for testbench use only and raytracer_pkg must be compiled first
`ifndef RAYTRACER_REF_SVH
`define RAYTRACER_REF_SVH

function automatic raytracer_pkg::rgb_t raytracer_ref(input raytracer_pkg::pixel_t px);
    raytracer_pkg::q16_t    raw_x;
    raytracer_pkg::q16_t    raw_y;
    raytracer_pkg::ray_t    dir;
    raytracer_pkg::ray_t    norm;
    raytracer_pkg::sphere_t sph;
    raytracer_pkg::q16_t    t;
    raytracer_pkg::q16_t    best_t;
    raytracer_pkg::rgb_t    rgb;
    logic                   best_hit;
    int                     best_idx;
    int                     diff;

    raw_x = ($signed({22'd0, px.x}) - (raytracer_pkg::SCREEN_W / 2))
            <<< raytracer_pkg::RAY_DIR_SHIFT;
    raw_y = ((raytracer_pkg::SCREEN_H / 2) - $signed({23'd0, px.y}))
            <<< raytracer_pkg::RAY_DIR_SHIFT;
    dir   = raytracer_pkg::q16_normalize(raw_x, raw_y, raytracer_pkg::RAY_DEPTH_Z);

    best_hit = 1'b0;
    best_t   = '0;
    best_idx = 0;
    for (int i = 0; i < raytracer_pkg::NUM_SPHERES; i++) begin
        if (raytracer_pkg::ray_sphere(dir, raytracer_pkg::SCENE[i], t) &&
            (!best_hit || t < best_t)) begin
            best_hit = 1'b1;
            best_t   = t;
            best_idx = i;
        end
    end
    if (!best_hit) begin
        return '{r: raytracer_pkg::BG_R, g: raytracer_pkg::BG_G, b: raytracer_pkg::BG_B};
    end

    sph  = raytracer_pkg::SCENE[best_idx];
    norm = raytracer_pkg::q16_normalize(raytracer_pkg::q16_mul(best_t, dir.x) - sph.cx,
                                        raytracer_pkg::q16_mul(best_t, dir.y) - sph.cy,
                                        raytracer_pkg::q16_mul(best_t, dir.z) - sph.cz);
    diff = int'(raytracer_pkg::q16_dot3(norm.x, norm.y, norm.z,
                                        raytracer_pkg::LIGHT_DIR.x,
                                        raytracer_pkg::LIGHT_DIR.y,
                                        raytracer_pkg::LIGHT_DIR.z) >>> 12);
    diff = (diff < 0) ? 0 :
           ((diff > raytracer_pkg::DIFFUSE_MAX) ? raytracer_pkg::DIFFUSE_MAX : diff);
    rgb.r = raytracer_pkg::clamp_u8((int'(sph.r) >>> 3) + ((int'(sph.r) * diff) >>> 4));
    rgb.g = raytracer_pkg::clamp_u8((int'(sph.g) >>> 3) + ((int'(sph.g) * diff) >>> 4));
    rgb.b = raytracer_pkg::clamp_u8((int'(sph.b) >>> 3) + ((int'(sph.b) * diff) >>> 4));
    return rgb;
endfunction

`endif

// File: verif/raytracer_tb.sv
// Runs under Verilator with --timing, stops at the first mismatch, expects the four-sphere scene
`timescale 1ns/100ps

module raytracer_tb;

    import raytracer_pkg::*;

    `include "raytracer_ref.svh"

    typedef struct packed {
        rgb_t   rgb;
        pixel_t px;
        int     due;
    } expect_t;

    logic    clk;
    logic    rst_n_i;
    pixel_t  pixel_i;
    logic    pixel_valid_i;
    rgb_t    rgb_o;
    logic    rgb_valid_o;
    int      seed = 33256;
    int      cycle_cnt = 0;
    int      sent_cnt = 0;
    int      recv_cnt = 0;
    expect_t exp_q [$];

    raytracer_top raytracer_top_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .rgb_o         (rgb_o),
        .rgb_valid_o   (rgb_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    // Ambient eighth plus diffuse sixteenths of the base colour
    function automatic logic [7:0] shade_rule(input logic [7:0] c, input int d);
        int v;
        v = int'(c) / 8 + (int'(c) * d) / 16;
        if (v > 255) begin
            v = 255;
        end
        return 8'(v);
    endfunction

    // True when some diffuse level turns sphere k's colour into rgb
    function automatic bit shaded_from(input rgb_t rgb, input int k);
        for (int d = 0; d <= DIFFUSE_MAX; d++) begin
            if (rgb.r == shade_rule(SCENE[k].r, d) && rgb.g == shade_rule(SCENE[k].g, d) &&
                rgb.b == shade_rule(SCENE[k].b, d)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Offset of 400 px per unit of x/z puts the ray through the centre
    function automatic pixel_t centre_pixel(input int k);
        longint scale;
        longint off_x;
        longint off_y;
        pixel_t px;
        scale = longint'(RAY_DEPTH_Z >>> RAY_DIR_SHIFT);
        off_x = (longint'(SCENE[k].cx) * scale) / longint'(SCENE[k].cz);
        off_y = (longint'(SCENE[k].cy) * scale) / longint'(SCENE[k].cz);
        px.x  = 10'(longint'(SCREEN_W / 2) + off_x);
        px.y  = 9'(longint'(SCREEN_H / 2) - off_y);
        return px;
    endfunction

    function automatic pixel_t random_pixel();
        pixel_t px;
        px.x = 10'($unsigned($random(seed)) % 32'(SCREEN_W));
        px.y = 9'($unsigned($random(seed)) % 32'(SCREEN_H));
        return px;
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic drive_pixel(input pixel_t px);
        expect_t e;
        pixel_i       = px;
        pixel_valid_i = 1'b1;
        e.rgb = raytracer_ref(px);
        e.px  = px;
        // Sampled on the next rising edge, then three register stages
        e.due = cycle_cnt + 3;
        exp_q.push_back(e);
        sent_cnt++;
        @(negedge clk);
    endtask

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            pixel_i       = random_pixel();
            pixel_valid_i = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited        = 0;
        pixel_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                fail_run("Timed out waiting for pending pixels to leave the pipeline");
            end
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling edge
    initial begin : compare_outputs
        expect_t e;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (rgb_valid_o === 1'b1) begin
                assert (exp_q.size() > 0)
                else fail_run("rgb_valid_o went high with no pixel pending");
                e = exp_q.pop_front();
                recv_cnt++;
                assert (cycle_cnt == e.due)
                else fail_run($sformatf(
                    "FAIL @ %0t: pixel (%0d,%0d) left at cycle %0d, expected %0d",
                    $time, e.px.x, e.px.y, cycle_cnt, e.due));
                assert (rgb_o === e.rgb)
                else fail_run($sformatf(
                    "FAIL @ %0t: pixel (%0d,%0d) gave %0d,%0d,%0d, expected %0d,%0d,%0d",
                    $time, e.px.x, e.px.y, rgb_o.r, rgb_o.g, rgb_o.b,
                    e.rgb.r, e.rgb.g, e.rgb.b));
            end else begin
                assert (rgb_valid_o === 1'b0)
                else fail_run("rgb_valid_o is unknown");
            end
        end
    end

    initial begin : stimulus
        pixel_t corners [4];
        pixel_t px;
        rgb_t   bg;
        rst_n_i       = 1'b0;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        bg            = {8'd0, 8'd0, 8'd32};
        corners[0]    = {10'd0, 9'd0};
        corners[1]    = {10'd639, 9'd479};
        corners[2]    = {10'd639, 9'd0};
        corners[3]    = {10'd0, 9'd479};

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        // No output may appear before the first pixel
        drive_idle(20);

        for (int i = 0; i < 4; i++) begin
            assert (raytracer_ref(corners[i]) == bg)
            else fail_run($sformatf("FAIL @ %0t: corner (%0d,%0d) is not background",
                                    $time, corners[i].x, corners[i].y));
            drive_pixel(corners[i]);
        end
        wait_drained(20);

        for (int k = 0; k < NUM_SPHERES; k++) begin
            px = centre_pixel(k);
            assert (shaded_from(raytracer_ref(px), k))
            else fail_run($sformatf("FAIL @ %0t: centre pixel of sphere %0d is not its shade",
                                    $time, k));
            drive_pixel(px);
        end
        // Inside the silhouettes of spheres 0 and 2, sphere 2 is nearer
        px = {10'd380, 9'd220};
        assert (shaded_from(raytracer_ref(px), 2) && !shaded_from(raytracer_ref(px), 0))
        else fail_run($sformatf(
            "FAIL @ %0t: overlap pixel not shaded by the nearer sphere", $time));
        drive_pixel(px);
        wait_drained(20);

        for (int i = 0; i < 200; i++) begin
            drive_pixel(random_pixel());
        end
        wait_drained(20);

        for (int i = 0; i < 300; i++) begin
            if ($random(seed) & 1) begin
                drive_pixel(random_pixel());
            end else begin
                drive_idle(1);
            end
        end
        wait_drained(20);
        drive_idle(20);

        if (exp_q.size() == 0 && recv_cnt == sent_cnt) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run($sformatf("Sent %0d pixels but received %0d colours", sent_cnt, recv_cnt));
        end
    end

endmodule

// File: hdl/raytracer_top.sv
// Three-cycle pipeline with no back-pressure so the consumer must take every output
`timescale 1ns/100ps

module raytracer_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  raytracer_pkg::pixel_t pixel_i,
    input  logic                  pixel_valid_i,
    output raytracer_pkg::rgb_t   rgb_o,
    output logic                  rgb_valid_o
);

    import raytracer_pkg::*;

    ray_t ray;
    logic ray_valid;
    hit_t hit_a;
    hit_t hit_b;
    logic hit_a_valid;
    logic hit_b_valid;

    ray_gen ray_gen_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .ray_o         (ray),
        .ray_valid_o   (ray_valid)
    );

    // Spheres 0 and 1
    sphere_bank #(.BANK_BASE(0)) sphere_bank_a_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ray_i       (ray),
        .ray_valid_i (ray_valid),
        .hit_o       (hit_a),
        .hit_valid_o (hit_a_valid)
    );

    // Spheres 2 and 3
    sphere_bank #(.BANK_BASE(2)) sphere_bank_b_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ray_i       (ray),
        .ray_valid_i (ray_valid),
        .hit_o       (hit_b),
        .hit_valid_o (hit_b_valid)
    );

    hit_shader hit_shader_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hit_a_i     (hit_a),
        .hit_b_i     (hit_b),
        .hit_valid_i (hit_a_valid),
        .rgb_o       (rgb_o),
        .rgb_valid_o (rgb_valid_o)
    );

    a_banks_lockstep: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        hit_a_valid == hit_b_valid
    ) else $error("sphere banks out of lockstep");

endmodule

// File: hdl/hit_shader.sv
// Single white light with a fixed direction and no shadows, both bank inputs must arrive together
`timescale 1ns/100ps

module hit_shader (
    input  logic                clk,
    input  logic                rst_n_i,
    input  raytracer_pkg::hit_t hit_a_i,
    input  raytracer_pkg::hit_t hit_b_i,
    input  logic                hit_valid_i,
    output raytracer_pkg::rgb_t rgb_o,
    output logic                rgb_valid_o
);

    import raytracer_pkg::*;

    hit_t    sel;
    sphere_t sph;
    ray_t    hit_pt;
    ray_t    normal;
    q16_t    ndotl;
    int      diff;
    rgb_t    rgb_d;

    // Ambient eighth plus diffuse share in sixteenths
    function automatic logic [7:0] shade_chan(input logic [7:0] c, input int d);
        return clamp_u8((int'(c) >>> 3) + ((int'(c) * d) >>> 4));
    endfunction

    always_comb begin
        // Bank A holds the lower sphere indices so it wins a tie
        if (hit_a_i.hit && (!hit_b_i.hit || hit_a_i.t <= hit_b_i.t)) begin
            sel = hit_a_i;
        end else begin
            sel = hit_b_i;
        end
        sph = SCENE[sel.idx];

        hit_pt.x = q16_mul(sel.t, sel.ray.x);
        hit_pt.y = q16_mul(sel.t, sel.ray.y);
        hit_pt.z = q16_mul(sel.t, sel.ray.z);
        normal   = q16_normalize(hit_pt.x - sph.cx, hit_pt.y - sph.cy, hit_pt.z - sph.cz);
        ndotl    = q16_dot3(normal.x, normal.y, normal.z,
                            LIGHT_DIR.x, LIGHT_DIR.y, LIGHT_DIR.z);

        diff = int'(ndotl >>> 12);
        if (diff < 0) begin
            diff = 0;
        end else if (diff > DIFFUSE_MAX) begin
            diff = DIFFUSE_MAX;
        end

        if (!sel.hit) begin
            rgb_d.r = BG_R;
            rgb_d.g = BG_G;
            rgb_d.b = BG_B;
        end else begin
            rgb_d.r = shade_chan(sph.r, diff);
            rgb_d.g = shade_chan(sph.g, diff);
            rgb_d.b = shade_chan(sph.b, diff);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rgb_valid_o <= 1'b0;
        end else begin
            rgb_valid_o <= hit_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid_i) begin
            rgb_o <= rgb_d;
        end
    end

endmodule

// File: hdl/sphere_bank.sv
// Searches SPHERES_PER_BANK spheres from BANK_BASE and the bank must fit inside SCENE
`timescale 1ns/100ps

module sphere_bank #(
    parameter int BANK_BASE = 0
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  raytracer_pkg::ray_t ray_i,
    input  logic                ray_valid_i,
    output raytracer_pkg::hit_t hit_o,
    output logic                hit_valid_o
);

    import raytracer_pkg::*;

    logic cand_hit [SPHERES_PER_BANK];
    q16_t cand_t   [SPHERES_PER_BANK];
    hit_t hit_d;

    always_comb begin
        hit_d.hit = 1'b0;
        hit_d.t   = '0;
        hit_d.idx = 2'(BANK_BASE);
        hit_d.ray = ray_i;
        // Strict compare so the lower index keeps a tie
        for (int i = 0; i < SPHERES_PER_BANK; i++) begin
            cand_hit[i] = ray_sphere(ray_i, SCENE[BANK_BASE + i], cand_t[i]);
            if (cand_hit[i] && (!hit_d.hit || cand_t[i] < hit_d.t)) begin
                hit_d.hit = 1'b1;
                hit_d.t   = cand_t[i];
                hit_d.idx = 2'(BANK_BASE + i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hit_valid_o <= 1'b0;
        end else begin
            hit_valid_o <= ray_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ray_valid_i) begin
            hit_o <= hit_d;
        end
    end

    a_hit_positive: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (hit_valid_o && hit_o.hit) |-> (hit_o.t > 0)
    ) else $error("bank %0d reported a hit with non-positive distance", BANK_BASE);

endmodule

// File: hdl/ray_gen.sv
// One pixel per clock with a fixed one-cycle latency and the raster is assumed to be 640x480
`timescale 1ns/100ps

module ray_gen (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  raytracer_pkg::pixel_t pixel_i,
    input  logic                  pixel_valid_i,
    output raytracer_pkg::ray_t   ray_o,
    output logic                  ray_valid_o
);

    import raytracer_pkg::*;

    q16_t centred_x;
    q16_t centred_y;
    q16_t raw_x;
    q16_t raw_y;
    ray_t dir_d;

    always_comb begin
        // Screen y grows downward, world y grows upward
        centred_x = $signed({22'd0, pixel_i.x}) - (SCREEN_W / 2);
        centred_y = (SCREEN_H / 2) - $signed({23'd0, pixel_i.y});
        raw_x     = centred_x <<< RAY_DIR_SHIFT;
        raw_y     = centred_y <<< RAY_DIR_SHIFT;
        dir_d     = q16_normalize(raw_x, raw_y, RAY_DEPTH_Z);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ray_valid_o <= 1'b0;
        end else begin
            ray_valid_o <= pixel_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid_i) begin
            ray_o <= dir_d;
        end
    end

    // Every primary ray points into the scene
    a_ray_forward: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ray_valid_o |-> (ray_o.z > 0)
    ) else $error("ray_o points away from the scene while ray_valid_o is high");

endmodule

// File: raytracer_pkg.sv
// Signed Q16.16 math and a scene fixed at elaboration time with the camera at the origin looking down +z
package raytracer_pkg;

    typedef logic signed [31:0] q16_t;

    localparam q16_t       Q16_ONE          = 32'sd65536;
    localparam int         NUM_SPHERES      = 4;
    localparam int         SPHERES_PER_BANK = 2;
    localparam int         SCREEN_W         = 640;
    localparam int         SCREEN_H         = 480;
    localparam int         RAY_DIR_SHIFT    = 14;
    localparam q16_t       RAY_DEPTH_Z      = 32'sd6553600;
    localparam logic [7:0] BG_R             = 8'd0;
    localparam logic [7:0] BG_G             = 8'd0;
    localparam logic [7:0] BG_B             = 8'd32;
    localparam int         DIFFUSE_MAX      = 16;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } pixel_t;

    typedef struct packed {
        q16_t x;
        q16_t y;
        q16_t z;
    } ray_t;

    typedef struct packed {
        logic       hit;
        q16_t       t;
        logic [1:0] idx;
        ray_t       ray;
    } hit_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        q16_t       cx;
        q16_t       cy;
        q16_t       cz;
        q16_t       radius;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } sphere_t;

    // Roughly (1, 1, -1) / sqrt(3), up and right and back toward the camera
    localparam ray_t LIGHT_DIR = '{x: 32'sd37838, y: 32'sd37838, z: -32'sd37838};

    // Sphere 2 sits in front of sphere 0 and overlaps it on screen
    localparam sphere_t SCENE [NUM_SPHERES] = '{
        '{cx: 32'sd0, cy: 32'sd0, cz: 32'sd655360, radius: 32'sd131072,
          r: 8'd255, g: 8'd64, b: 8'd64},
        '{cx: -32'sd196608, cy: 32'sd65536, cz: 32'sd786432, radius: 32'sd98304,
          r: 8'd64, g: 8'd255, b: 8'd64},
        '{cx: 32'sd98304, cy: 32'sd32768, cz: 32'sd393216, radius: 32'sd65536,
          r: 8'd64, g: 8'd64, b: 8'd255},
        '{cx: 32'sd196608, cy: -32'sd131072, cz: 32'sd983040, radius: 32'sd163840,
          r: 8'd255, g: 8'd220, b: 8'd64}
    };

    function automatic q16_t q16_mul(input q16_t a, input q16_t b);
        logic signed [63:0] prod;
        // Round to nearest before dropping the fraction
        prod = 64'(a) * 64'(b) + 64'(Q16_ONE >>> 1);
        return prod[47:16];
    endfunction

    function automatic q16_t q16_div(input q16_t a, input q16_t b);
        logic signed [63:0] num;
        logic signed [63:0] quo;
        if (b == 0) begin
            return (a >= 0) ? 32'sd2147483647 : -32'sd2147483647;
        end
        num = 64'(a) <<< 16;
        quo = num / 64'(b);
        return quo[31:0];
    endfunction

    function automatic q16_t q16_dot3(input q16_t ax, input q16_t ay, input q16_t az,
                                      input q16_t bx, input q16_t by, input q16_t bz);
        logic signed [63:0] px;
        logic signed [63:0] py;
        logic signed [63:0] pz;
        px = (64'(ax) * 64'(bx)) >>> 16;
        py = (64'(ay) * 64'(by)) >>> 16;
        pz = (64'(az) * 64'(bz)) >>> 16;
        return px[31:0] + py[31:0] + pz[31:0];
    endfunction

    function automatic q16_t q16_sqrt(input q16_t a);
        logic [63:0] v;
        logic [63:0] rem;
        logic [63:0] root;
        if (a <= 0) begin
            return '0;
        end
        v    = {32'h0, a} << 16;
        rem  = '0;
        root = '0;
        // Digit-by-digit root, two input bits per step
        for (int i = 23; i >= 0; i--) begin
            rem = (rem << 2) | ((v >> (2 * i)) & 64'd3);
            if (rem >= ((root << 2) | 64'd1)) begin
                rem  = rem - ((root << 2) | 64'd1);
                root = (root << 1) | 64'd1;
            end else begin
                root = root << 1;
            end
        end
        return root[31:0];
    endfunction

    function automatic ray_t q16_normalize(input q16_t x, input q16_t y, input q16_t z);
        q16_t mag;
        ray_t n;
        mag = q16_sqrt(q16_dot3(x, y, z, x, y, z));
        if (mag <= 0) begin
            n = '0;
        end else begin
            n.x = q16_div(x, mag);
            n.y = q16_div(y, mag);
            n.z = q16_div(z, mag);
        end
        return n;
    endfunction

    // Ray from the origin, returns the smaller positive root in t
    function automatic logic ray_sphere(input ray_t d, input sphere_t s, output q16_t t);
        q16_t a;
        q16_t half_b;
        q16_t c;
        q16_t disc;
        q16_t root;
        q16_t t0;
        q16_t t1;
        a      = q16_dot3(d.x, d.y, d.z, d.x, d.y, d.z);
        half_b = q16_dot3(-s.cx, -s.cy, -s.cz, d.x, d.y, d.z);
        c      = q16_dot3(-s.cx, -s.cy, -s.cz, -s.cx, -s.cy, -s.cz)
               - q16_mul(s.radius, s.radius);
        disc   = q16_mul(half_b, half_b) - q16_mul(a, c);
        t      = '0;
        if (disc < 0 || a == 0) begin
            return 1'b0;
        end
        root = q16_sqrt(disc);
        t0   = q16_div(-half_b - root, a);
        t1   = q16_div(-half_b + root, a);
        if (t0 > 0 && (t1 <= 0 || t0 <= t1)) begin
            t = t0;
            return 1'b1;
        end
        if (t1 > 0) begin
            t = t1;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [7:0] clamp_u8(input int v);
        if (v < 0) begin
            return 8'd0;
        end
        if (v > 255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

endpackage
